/* project.f */
source/display_pkg.sv
source/divide_by_ten_stage.sv
source/decimal_digit_path.sv
source/hex_digit_path.sv
source/display_select.sv
source/display_top.sv
testbench/tb_clock.sv
testbench/tb_display.sv

/* run.sh */
#!/bin/sh
# build the display testbench with Verilator, run it, judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module tb_display \
	-f project.f -o sim_display > build.log 2>&1 \
	|| { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/sim_display > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log

grep -q "Result: FAILED" sim.log && { echo "testbench reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no result line in the log"; exit 1; }
exit 0

/* testbench/tb_display.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_display;

	localparam int CLK_PERIOD_NS = 40;
	localparam int RESET_CYCLES = 8;
	localparam int PIPE_DEPTH = 7; // registers between the input pins and hex_display
	localparam int NUM_HEX_CORNERS = 3;
	localparam int NUM_DEC_CORNERS = 10;
	localparam int HEX_RANDOM = 40;
	localparam int DEC_RANDOM = 60;
	localparam int MIXED_CYCLES = 80;
	localparam int DRAIN_CYCLES = 10;
	localparam int MARGIN_CYCLES = 50;
	localparam int TOTAL_CYCLES = 2 * RESET_CYCLES + NUM_HEX_CORNERS + HEX_RANDOM
		+ NUM_DEC_CORNERS + DEC_RANDOM + MIXED_CYCLES + 2 * DRAIN_CYCLES;

	localparam display_pkg::seg_array_t ALL_DARK = '1;

	// active-high patterns, bit order {dp, m, lt, lb, b, rb, rt, t}
	localparam logic [7:0] SEG_TABLE [16] = '{
		8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
		8'h7f, 8'h67, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71
	};

	localparam display_pkg::number_t HEX_CORNERS [NUM_HEX_CORNERS] = '{
		16'h0000, 16'hffff, 16'ha5c3
	};

	localparam display_pkg::number_t DEC_CORNERS [NUM_DEC_CORNERS] = '{
		16'd0, 16'd9, 16'd10, 16'd99, 16'd100,
		16'd1000, 16'd10000, 16'd10009, 16'd60000, 16'd65535
	};

	logic clk;
	logic rst;
	display_pkg::number_t number;
	logic base_dec;
	display_pkg::seg_array_t hex_display;

	display_pkg::seg_array_t pipe [PIPE_DEPTH]; // expected outputs in flight
	int fill_count = 0; // data edges since the last reset edge
	logic armed = 1'b0; // set once the first reset edge is seen
	int checks = 0;
	int errors = 0;
	logic [31:0] rng_state = 32'hcc51efd3;

	tb_clock u_clock (
		.clk(clk)
	);

	display_top u_dut (
		.clk(clk),
		.rst(rst),
		.number(number),
		.base_dec(base_dec),
		.hex_display(hex_display)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	// four hex digits, top two displays dark, active low
	function automatic display_pkg::seg_array_t hex_view(input display_pkg::number_t n);
		display_pkg::seg_array_t v;
		logic [7:0] seg;
		v = '1;
		for (int k = 5; k >= 0; k--) begin
			if (k >= 4) begin
				seg = 8'hff;
			end else begin
				seg = ~SEG_TABLE[n[k*4 +: 4]];
			end
			v = {v[39:0], seg}; // display k ends in the low byte after the last pass
		end
		return v;
	endfunction

	// decimal digits with leading zeros dark, display 0 always lit
	function automatic display_pkg::seg_array_t decimal_view(input display_pkg::number_t n);
		display_pkg::seg_array_t v;
		display_pkg::digit_t digit [6];
		logic [7:0] seg;
		int value;
		int top;
		value = int'(n);
		top = 0;
		for (int k = 0; k < 6; k++) begin
			digit[k] = display_pkg::digit_t'(value % 10);
			value = value / 10;
			if (digit[k] != 4'd0) begin
				top = k; // highest non-zero digit
			end
		end
		v = '1;
		for (int k = 5; k >= 0; k--) begin
			if (k <= top) begin
				seg = ~SEG_TABLE[digit[k]];
			end else begin
				seg = 8'hff;
			end
			v = {v[39:0], seg};
		end
		return v;
	endfunction

	task automatic drive(input display_pkg::number_t value, input logic dec);
		@(posedge clk);
		#2;
		number = value;
		base_dec = dec;
	endtask

	// called 2 ns after an edge or at time zero
	task automatic apply_reset();
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;
	endtask

	// reference pipeline, one entry per register stage
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < PIPE_DEPTH; i++) begin
				pipe[i] = ALL_DARK; // whatever was in flight is lost
			end
			fill_count = 0;
			armed = 1'b1;
		end else begin
			for (int i = PIPE_DEPTH - 1; i > 0; i--) begin
				pipe[i] = pipe[i-1];
			end
			pipe[0] = base_dec ? decimal_view(number) : hex_view(number);
			if (fill_count < PIPE_DEPTH) begin
				fill_count++;
			end
		end
	end

	// outputs are stable half a period after the edge
	always @(negedge clk) begin
		if (armed) begin
			checks++;
			assert (hex_display === pipe[PIPE_DEPTH-1]) else begin
				errors++;
				$display("[ERROR] %0t ns: hex_display is %h, expected %h",
					$time, hex_display, pipe[PIPE_DEPTH-1]);
			end
			if (fill_count < PIPE_DEPTH) begin
				assert (hex_display === ALL_DARK) else begin
					errors++;
					$display("[ERROR] %0t ns: hex_display is %h, expected %h while filling",
						$time, hex_display, ALL_DARK);
				end
			end
			for (int k = 0; k < display_pkg::NUM_DISPLAYS; k++) begin
				assert (hex_display[k*8+7] === 1'b1) else begin
					errors++;
					$display("[ERROR] %0t ns: hex_display[%0d] is %b, expected 1",
						$time, k*8+7, hex_display[k*8+7]);
				end
			end
		end
	end

	initial begin
		logic [31:0] r;
		display_pkg::number_t n;
		rst = 1'b1;
		number = '0;
		base_dec = 1'b0;
		apply_reset();

		for (int i = 0; i < NUM_HEX_CORNERS; i++) begin
			drive(HEX_CORNERS[i], 1'b0);
		end
		for (int i = 0; i < HEX_RANDOM; i++) begin
			next_random(r);
			drive(r[15:0], 1'b0);
		end

		for (int i = 0; i < NUM_DEC_CORNERS; i++) begin
			drive(DEC_CORNERS[i], 1'b1);
		end
		for (int i = 0; i < DEC_RANDOM; i++) begin
			next_random(r);
			n = r[15:0] >> r[19:16]; // spread over all digit counts
			drive(n, 1'b1);
		end

		// second reset with data still in the pipes
		apply_reset();

		// new number and mode on every edge
		for (int i = 0; i < MIXED_CYCLES; i++) begin
			next_random(r);
			n = r[20] ? r[15:0] : (r[15:0] >> r[19:16]);
			drive(n, r[31]);
		end
		for (int i = 0; i < DRAIN_CYCLES; i++) begin
			drive(n, base_dec);
		end
		repeat (DRAIN_CYCLES) @(posedge clk);
		@(negedge clk);
		#1;

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS);
		$display("timeout: the stimulus did not finish within %0d clock cycles",
			TOTAL_CYCLES + MARGIN_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	output logic clk
);

	localparam int HALF_PERIOD_NS = 20; // 40 ns period

	initial begin
		clk = 1'b0;
	end

	always begin
		#(HALF_PERIOD_NS);
		clk = ~clk;
	end

endmodule

`default_nettype wire

/* source/display_top.sv */
`timescale 1ns/100ps
`default_nettype none

module display_top (
	input wire clk,
	input wire rst,
	input wire display_pkg::number_t number,
	input wire base_dec, // 1 decimal, 0 hex
	output display_pkg::seg_array_t hex_display
);

	display_pkg::seg_array_t dec_seg; // active high
	display_pkg::seg_array_t hex_seg; // active high

	decimal_digit_path u_decimal (
		.clk(clk),
		.rst(rst),
		.number(number),
		.dec_seg(dec_seg)
	);

	hex_digit_path u_hex (
		.clk(clk),
		.rst(rst),
		.number(number),
		.hex_seg(hex_seg)
	);

	display_select u_select (
		.clk(clk),
		.rst(rst),
		.base_dec(base_dec),
		.dec_seg(dec_seg),
		.hex_seg(hex_seg),
		.hex_display(hex_display)
	);

endmodule

`default_nettype wire

/* source/display_select.sv */
`timescale 1ns/100ps
`default_nettype none

module display_select (
	input wire clk,
	input wire rst,
	input wire base_dec,
	input wire display_pkg::seg_array_t dec_seg,
	input wire display_pkg::seg_array_t hex_seg,
	output display_pkg::seg_array_t hex_display
);

	logic [display_pkg::PATH_LATENCY-1:0] mode_delay; // travels with the data
	logic mode_dec; // mode paired with the segments now at the inputs
	display_pkg::seg_array_t seg_chosen;

	// resets to hex so the dark hex line is shown while the pipes fill
	always_ff @(posedge clk) begin
		if (rst) begin
			mode_delay <= '0;
		end else begin
			mode_delay <= {mode_delay[display_pkg::PATH_LATENCY-2:0], base_dec};
		end
	end

	assign mode_dec = mode_delay[display_pkg::PATH_LATENCY-1];
	assign seg_chosen = mode_dec ? dec_seg : hex_seg;

	// segments light on a low level
	always_ff @(posedge clk) begin
		if (rst) begin
			hex_display <= '1; // all dark
		end else begin
			hex_display <= ~seg_chosen;
		end
	end

endmodule

`default_nettype wire

/* source/hex_digit_path.sv */
`timescale 1ns/100ps
`default_nettype none

module hex_digit_path (
	input wire clk,
	input wire rst,
	input wire display_pkg::number_t number,
	output display_pkg::seg_array_t hex_seg
);

	display_pkg::seg_array_t seg_now; // encoded this cycle
	display_pkg::seg_array_t delay_line [0:display_pkg::PATH_LATENCY-1];

	// low nibble on display 0, top two displays dark
	always_comb begin
		seg_now = '0;
		for (int k = 0; k < display_pkg::NUM_DISPLAYS; k++) begin
			if (k < display_pkg::HEX_DIGITS) begin
				seg_now[k*8 +: 8] = display_pkg::seg_encode(number[k*4 +: 4]);
			end else begin
				seg_now[k*8 +: 8] = display_pkg::SEG_OFF;
			end
		end
	end

	// matches the decimal divider chain plus its encode register
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < display_pkg::PATH_LATENCY; i++) begin
				delay_line[i] <= {display_pkg::NUM_DISPLAYS{display_pkg::SEG_OFF}};
			end
		end else begin
			delay_line[0] <= seg_now;
			for (int i = 1; i < display_pkg::PATH_LATENCY; i++) begin
				delay_line[i] <= delay_line[i-1];
			end
		end
	end

	assign hex_seg = delay_line[display_pkg::PATH_LATENCY-1];

endmodule

`default_nettype wire

/* source/decimal_digit_path.sv */
`timescale 1ns/100ps
`default_nettype none

module decimal_digit_path (
	input wire clk,
	input wire rst,
	input wire display_pkg::number_t number,
	output display_pkg::seg_array_t dec_seg
);

	// index 0 is the path input, index k is the output of stage k-1
	display_pkg::number_t stage_quot [0:display_pkg::DEC_STAGES];
	display_pkg::digit_t [display_pkg::DEC_STAGES-1:0] stage_digits [0:display_pkg::DEC_STAGES];

	display_pkg::digit_t [display_pkg::NUM_DISPLAYS-1:0] digits; // digit 0 is ones
	display_pkg::seg_array_t seg_next;
	logic zero_above; // this digit and all higher ones are zero

	assign stage_quot[0] = number;
	assign stage_digits[0] = '0; // no digits found yet

	genvar g;
	generate
		for (g = 0; g < display_pkg::DEC_STAGES; g++) begin : g_div
			divide_by_ten_stage u_stage (
				.clk(clk),
				.rst(rst),
				.dividend_in(stage_quot[g]),
				.digits_in(stage_digits[g]),
				.quotient_out(stage_quot[g+1]),
				.digits_out(stage_digits[g+1])
			);
		end
	endgenerate

	// last quotient is below ten for any 16-bit input
	assign digits = {stage_quot[display_pkg::DEC_STAGES][3:0],
		stage_digits[display_pkg::DEC_STAGES]};

	// leading-zero blanking, scanned from the top display down
	always_comb begin
		zero_above = 1'b1;
		seg_next = '0;
		for (int k = display_pkg::NUM_DISPLAYS - 1; k >= 0; k--) begin
			zero_above = zero_above && (digits[k] == '0);
			if (zero_above && k != 0) begin
				seg_next[k*8 +: 8] = display_pkg::SEG_OFF;
			end else begin
				seg_next[k*8 +: 8] = display_pkg::seg_encode(digits[k]); // ones always shown
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_seg <= {display_pkg::NUM_DISPLAYS{display_pkg::SEG_OFF}};
		end else begin
			dec_seg <= seg_next;
		end
	end

endmodule

`default_nettype wire

/* source/divide_by_ten_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module divide_by_ten_stage (
	input wire clk,
	input wire rst,
	input wire display_pkg::number_t dividend_in,
	input wire display_pkg::digit_t [display_pkg::DEC_STAGES-1:0] digits_in,
	output display_pkg::number_t quotient_out,
	output display_pkg::digit_t [display_pkg::DEC_STAGES-1:0] digits_out
);

	display_pkg::number_t partial; // running remainder
	display_pkg::number_t shifted; // remainder with next dividend bit
	display_pkg::number_t quotient;
	logic [16:0] trial; // bit 16 set when ten fits

	// restoring subtract-and-shift, msb first
	always_comb begin
		partial = '0;
		shifted = '0;
		quotient = '0;
		trial = '0;
		for (int i = $bits(display_pkg::number_t) - 1; i >= 0; i--) begin
			shifted = {partial[14:0], dividend_in[i]}; // bring down next bit
			trial = {1'b0, shifted} + 17'h0_fff6; // adds minus ten
			quotient[i] = trial[16];
			partial = trial[16] ? trial[15:0] : shifted; // restore on borrow
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			quotient_out <= '0;
			digits_out <= '0;
		end else begin
			quotient_out <= quotient;
			// new digit enters at the top, earlier ones move down
			digits_out <= {display_pkg::digit_t'(partial[3:0]),
				digits_in[display_pkg::DEC_STAGES-1:1]};
		end
	end

endmodule

`default_nettype wire

/* source/display_pkg.sv */
`default_nettype none

package display_pkg;

	localparam int NUM_DISPLAYS = 6; // seven-segment digits on the board
	localparam int DEC_STAGES = 5; // enough for 65535
	localparam int HEX_DIGITS = 4; // one per nibble
	localparam int PATH_LATENCY = 6; // divider stages plus encode register

	typedef logic [15:0] number_t;
	typedef logic [3:0] digit_t;
	typedef logic [7:0] seg_t; // {dp, m, lt, lb, b, rb, rt, t}
	typedef logic [NUM_DISPLAYS*8-1:0] seg_array_t; // display 0 in low byte

	localparam seg_t SEG_OFF = 8'h00; // active high, so dark

	// active-high pattern, decimal point never lit
	//  --t--
	// lt   rt
	//  --m--
	// lb   rb
	//  --b--  dp
	function automatic seg_t seg_encode(input digit_t digit);
		seg_t seg;
		seg = SEG_OFF;
		case (digit)
			4'h0: seg = 8'b0_0111111;
			4'h1: seg = 8'b0_0000110;
			4'h2: seg = 8'b0_1011011;
			4'h3: seg = 8'b0_1001111;
			4'h4: seg = 8'b0_1100110;
			4'h5: seg = 8'b0_1101101;
			4'h6: seg = 8'b0_1111101;
			4'h7: seg = 8'b0_0000111;
			4'h8: seg = 8'b0_1111111;
			4'h9: seg = 8'b0_1100111;
			4'ha: seg = 8'b0_1110111;
			4'hb: seg = 8'b0_1111100; // lower case b
			4'hc: seg = 8'b0_0111001;
			4'hd: seg = 8'b0_1011110; // lower case d
			4'he: seg = 8'b0_1111001;
			4'hf: seg = 8'b0_1110001;
			default: seg = SEG_OFF;
		endcase
		return seg;
	endfunction

endpackage

`default_nettype wire
